// ==== wisc_cfg.svh ====
`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// Datapath and instruction width
`define WISC_XLEN 16
// Architectural registers, R7 is ordinary here
`define WISC_NREG 8
`define WISC_MEM_AW 8 // Word address bits
`define WISC_MEM_DEPTH 256 // Words in unified memory

`endif

// ==== isa_pkg.sv ====
package isa_pkg;

	// Major opcode, instruction bits 15:11
	typedef enum logic [4:0] {
		OP_HALT = 5'b00000,
		OP_NOP = 5'b00001,
		OP_ADDI = 5'b01000,
		OP_SUBI = 5'b01001,
		OP_ORI = 5'b01010,
		OP_ANDI = 5'b01011,
		OP_ST = 5'b10000,
		OP_LD = 5'b10001,
		OP_SLBI = 5'b10010,
		OP_ROLI = 5'b10100,
		OP_SLLI = 5'b10101,
		OP_RORI = 5'b10110,
		OP_SRAI = 5'b10111,
		OP_LBI = 5'b11000,
		OP_RSHIFT = 5'b11010, // ROL/SLL/ROR/SRA by func bits
		OP_RALU = 5'b11011 // ADD/SUB/OR/AND by func bits
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1, // b minus a
		ALU_OR = 4'd2,
		ALU_AND = 4'd3,
		ALU_ROL = 4'd4,
		ALU_SLL = 4'd5,
		ALU_ROR = 4'd6,
		ALU_SRA = 4'd7,
		ALU_PASSB = 4'd8 // Operand b straight through
	} alu_op_e;

	// Nine classes need a 4-bit encoding
	typedef enum logic [3:0] {
		CLS_ALU_R = 4'd0,
		CLS_ALU_I = 4'd1,
		CLS_LOAD = 4'd2,
		CLS_STORE = 4'd3,
		CLS_LBI = 4'd4,
		CLS_SLBI = 4'd5,
		CLS_NOP = 4'd6,
		CLS_HALT = 4'd7,
		CLS_ILLEGAL = 4'd8
	} instr_class_e;

endpackage

// ==== core_pkg.sv ====
package core_pkg;

	typedef enum logic [2:0] {
		ST_IDLE = 3'd0, // Waiting for start
		ST_FETCH = 3'd1,
		ST_EXEC = 3'd2,
		ST_MEM = 3'd3, // LD and ST only
		ST_WB = 3'd4,
		ST_HALT = 3'd5
	} core_state_e;

	// Memory requester, listed in priority order
	typedef enum logic [1:0] {
		REQ_NONE = 2'd0,
		REQ_HOST = 2'd1,
		REQ_DATA = 2'd2,
		REQ_FETCH = 2'd3
	} mem_req_e;

endpackage

// ==== alu_destination_decode.sv ====
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module alu_destination_decode import isa_pkg::*; (
	input logic [`WISC_XLEN-1:0] instr,
	output logic [2:0] rd,
	output logic we_reg,
	output alu_op_e alu_op,
	output instr_class_e instr_class
);

	opcode_e opcode;
	logic [1:0] func;
	logic [2:0] rd_imm;
	logic [2:0] rd_reg;
	logic [2:0] rd_ld_imm;

	assign opcode = opcode_e'(instr[15:11]);
	assign func = instr[1:0];
	assign rd_imm = instr[7:5]; // Immediate format
	assign rd_reg = instr[4:2]; // Register format
	assign rd_ld_imm = instr[10:8]; // LBI and SLBI

	always_comb begin
		rd = 3'd0;
		we_reg = 1'b0;
		alu_op = ALU_PASSB;
		instr_class = CLS_ILLEGAL; // Anything not listed below
		case (opcode)
			OP_RALU, OP_RSHIFT: begin
				rd = rd_reg;
				we_reg = 1'b1;
				instr_class = CLS_ALU_R;
				// Opcode bit 11 picks the add/logic group
				alu_op = alu_op_e'({1'b0, ~instr[11], func});
			end
			OP_ADDI, OP_SUBI, OP_ORI, OP_ANDI: begin
				rd = rd_imm;
				we_reg = 1'b1;
				instr_class = CLS_ALU_I;
				alu_op = alu_op_e'({2'b00, instr[12:11]});
			end
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRAI: begin
				rd = rd_imm;
				we_reg = 1'b1;
				instr_class = CLS_ALU_I;
				alu_op = alu_op_e'({2'b01, instr[12:11]});
			end
			OP_LD: begin
				rd = rd_imm;
				we_reg = 1'b1;
				alu_op = ALU_ADD; // Rs plus offset
				instr_class = CLS_LOAD;
			end
			OP_ST: begin
				alu_op = ALU_ADD;
				instr_class = CLS_STORE;
			end
			OP_LBI: begin
				rd = rd_ld_imm;
				we_reg = 1'b1;
				instr_class = CLS_LBI;
			end
			OP_SLBI: begin
				rd = rd_ld_imm;
				we_reg = 1'b1;
				instr_class = CLS_SLBI;
			end
			OP_NOP: instr_class = CLS_NOP;
			OP_HALT: instr_class = CLS_HALT;
			default: instr_class = CLS_ILLEGAL;
		endcase
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module alu import isa_pkg::*; (
	input logic [`WISC_XLEN-1:0] a,
	input logic [`WISC_XLEN-1:0] b,
	input alu_op_e op,
	output logic [`WISC_XLEN-1:0] result
);

	logic [3:0] amt;
	logic [2*`WISC_XLEN-1:0] rol_w;
	logic [2*`WISC_XLEN-1:0] ror_w;
	logic [`WISC_XLEN-1:0] sra_w;

	assign amt = b[3:0]; // Shift amount from low bits of b

	// Rotates work on a doubled copy of a
	assign rol_w = {a, a} << amt;
	assign ror_w = {a, a} >> amt;
	assign sra_w = $signed(a) >>> amt;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = b - a; // Rt minus Rs, imm minus Rs
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			ALU_ROL: result = rol_w[2*`WISC_XLEN-1:`WISC_XLEN];
			ALU_SLL: result = a << amt;
			ALU_ROR: result = ror_w[`WISC_XLEN-1:0];
			ALU_SRA: result = sra_w;
			ALU_PASSB: result = b;
			default: result = b;
		endcase
	end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module mem_arbiter import core_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic host_req,
	input logic host_we,
	input logic [`WISC_MEM_AW-1:0] host_addr,
	input logic [`WISC_XLEN-1:0] host_wdata,
	output logic host_done,
	output logic [`WISC_XLEN-1:0] host_rdata,
	input logic data_req,
	input logic data_we,
	input logic [`WISC_MEM_AW-1:0] data_addr,
	input logic [`WISC_XLEN-1:0] data_wdata,
	output logic data_done,
	output logic [`WISC_XLEN-1:0] data_rdata,
	input logic fetch_req,
	input logic [`WISC_MEM_AW-1:0] fetch_addr,
	output logic fetch_done,
	output logic [`WISC_XLEN-1:0] fetch_rdata
);

	logic [`WISC_XLEN-1:0] mem [`WISC_MEM_DEPTH];
	logic host_pend, data_pend, fetch_pend;
	logic host_we_q, data_we_q;
	logic [`WISC_MEM_AW-1:0] host_addr_q, data_addr_q, fetch_addr_q;
	logic [`WISC_XLEN-1:0] host_wdata_q, data_wdata_q;
	logic [`WISC_XLEN-1:0] rdata_q;
	mem_req_e sel, served;
	logic acc_we;
	logic [`WISC_MEM_AW-1:0] acc_addr;
	logic [`WISC_XLEN-1:0] acc_wdata;

	// Fixed priority among pending requests
	always_comb begin
		sel = REQ_NONE;
		acc_we = 1'b0;
		acc_addr = fetch_addr_q;
		acc_wdata = data_wdata_q;
		if (host_pend) begin
			sel = REQ_HOST;
			acc_we = host_we_q;
			acc_addr = host_addr_q;
			acc_wdata = host_wdata_q;
		end else if (data_pend) begin
			sel = REQ_DATA;
			acc_we = data_we_q;
			acc_addr = data_addr_q;
		end else if (fetch_pend) begin
			sel = REQ_FETCH;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			host_pend <= 1'b0;
			data_pend <= 1'b0;
			fetch_pend <= 1'b0;
			served <= REQ_NONE;
		end else begin
			served <= sel; // Done follows one cycle after service
			if (host_req) host_pend <= 1'b1;
			else if (sel == REQ_HOST) host_pend <= 1'b0;
			if (data_req) data_pend <= 1'b1;
			else if (sel == REQ_DATA) data_pend <= 1'b0;
			if (fetch_req) fetch_pend <= 1'b1;
			else if (sel == REQ_FETCH) fetch_pend <= 1'b0;
		end
	end

	// Request fields and the array itself
	always_ff @(posedge clk) begin
		if (host_req) begin
			host_we_q <= host_we;
			host_addr_q <= host_addr;
			host_wdata_q <= host_wdata;
		end
		if (data_req) begin
			data_we_q <= data_we;
			data_addr_q <= data_addr;
			data_wdata_q <= data_wdata;
		end
		if (fetch_req) fetch_addr_q <= fetch_addr;
		if (sel != REQ_NONE) begin
			rdata_q <= mem[acc_addr]; // Read before write
			if (acc_we) mem[acc_addr] <= acc_wdata;
		end
	end

	assign host_done = (served == REQ_HOST);
	assign data_done = (served == REQ_DATA);
	assign fetch_done = (served == REQ_FETCH);
	assign host_rdata = rdata_q;
	assign data_rdata = rdata_q;
	assign fetch_rdata = rdata_q;

endmodule

// ==== wisc_core.sv ====
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module wisc_core import isa_pkg::*, core_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	output logic fetch_req,
	output logic [`WISC_MEM_AW-1:0] fetch_addr,
	input logic fetch_done,
	input logic [`WISC_XLEN-1:0] fetch_rdata,
	output logic data_req,
	output logic data_we,
	output logic [`WISC_MEM_AW-1:0] data_addr,
	output logic [`WISC_XLEN-1:0] data_wdata,
	input logic data_done,
	input logic [`WISC_XLEN-1:0] data_rdata,
	output logic halted,
	output logic illegal,
	output logic retire,
	output logic [`WISC_MEM_AW-1:0] retire_pc,
	output logic retire_we,
	output logic [2:0] retire_rd,
	output logic [`WISC_XLEN-1:0] retire_data
);

	core_state_e state;
	logic [`WISC_MEM_AW-1:0] pc;
	logic [`WISC_XLEN-1:0] ir;
	logic [`WISC_XLEN-1:0] rf [`WISC_NREG];
	logic [`WISC_XLEN-1:0] res_q;
	logic illegal_q;
	logic [2:0] rd;
	logic we_reg;
	alu_op_e alu_op;
	instr_class_e cls;
	logic [`WISC_XLEN-1:0] rs_val, rt_val;
	logic [`WISC_XLEN-1:0] op_b;
	logic [`WISC_XLEN-1:0] alu_result;
	logic stop;

	alu_destination_decode dec_i (
		.instr(ir),
		.rd(rd),
		.we_reg(we_reg),
		.alu_op(alu_op),
		.instr_class(cls)
	);

	alu alu_i (
		.a(rs_val),
		.b(op_b),
		.op(alu_op),
		.result(alu_result)
	);

	assign rs_val = rf[ir[10:8]]; // Also Rd for SLBI
	assign rt_val = rf[ir[7:5]]; // Also store data for ST

	// Operand b by instruction class
	always_comb begin
		case (cls)
			CLS_ALU_R: op_b = rt_val;
			CLS_ALU_I: begin
				if (alu_op == ALU_OR || alu_op == ALU_AND)
					op_b = {{(`WISC_XLEN-5){1'b0}}, ir[4:0]};
				else
					op_b = {{(`WISC_XLEN-5){ir[4]}}, ir[4:0]};
			end
			CLS_LOAD, CLS_STORE: op_b = {{(`WISC_XLEN-5){ir[4]}}, ir[4:0]};
			CLS_LBI: op_b = {{(`WISC_XLEN-8){ir[7]}}, ir[7:0]};
			CLS_SLBI: op_b = {rs_val[`WISC_XLEN-9:0], ir[7:0]}; // Rd << 8 | imm
			default: op_b = rt_val;
		endcase
	end

	assign stop = (cls == CLS_HALT) || (cls == CLS_ILLEGAL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			pc <= '0;
			fetch_req <= 1'b0;
			data_req <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			fetch_req <= 1'b0; // Strobes last one cycle
			data_req <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_FETCH;
						fetch_req <= 1'b1;
					end
				end
				ST_FETCH: if (fetch_done) state <= ST_EXEC;
				ST_EXEC: begin
					if (cls == CLS_LOAD || cls == CLS_STORE) begin
						state <= ST_MEM;
						data_req <= 1'b1;
					end else begin
						state <= ST_WB;
					end
				end
				ST_MEM: if (data_done) state <= ST_WB;
				ST_WB: begin
					pc <= pc + {{(`WISC_MEM_AW-1){1'b0}}, 1'b1};
					if (stop) begin
						state <= ST_HALT;
						if (cls == CLS_ILLEGAL) illegal_q <= 1'b1;
					end else begin
						state <= ST_FETCH;
						fetch_req <= 1'b1;
					end
				end
				ST_HALT: state <= ST_HALT; // Only reset leaves
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH && fetch_done) ir <= fetch_rdata;
		if (state == ST_EXEC) res_q <= alu_result;
		if (state == ST_MEM && data_done && cls == CLS_LOAD) res_q <= data_rdata;
		if (state == ST_WB && we_reg) rf[rd] <= res_q;
	end

	assign fetch_addr = pc;
	assign data_we = (cls == CLS_STORE);
	assign data_addr = res_q[`WISC_MEM_AW-1:0]; // Truncated effective address
	assign data_wdata = rt_val;

	assign retire = (state == ST_WB);
	assign retire_pc = pc;
	assign retire_we = we_reg;
	assign retire_rd = rd;
	assign retire_data = res_q;

	// Status rises together with the final retire
	assign halted = (state == ST_HALT) || (retire && stop);
	assign illegal = illegal_q || (retire && cls == CLS_ILLEGAL);

endmodule

// ==== wisc_top.sv ====
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module wisc_top (
	input logic clk,
	input logic rst_n,
	input logic host_req,
	input logic host_we,
	input logic [`WISC_MEM_AW-1:0] host_addr,
	input logic [`WISC_XLEN-1:0] host_wdata,
	output logic host_done,
	output logic [`WISC_XLEN-1:0] host_rdata,
	input logic start,
	output logic halted,
	output logic illegal,
	output logic retire,
	output logic [`WISC_MEM_AW-1:0] retire_pc,
	output logic retire_we,
	output logic [2:0] retire_rd,
	output logic [`WISC_XLEN-1:0] retire_data
);

	logic fetch_req, fetch_done;
	logic [`WISC_MEM_AW-1:0] fetch_addr;
	logic [`WISC_XLEN-1:0] fetch_rdata;
	logic data_req, data_we, data_done;
	logic [`WISC_MEM_AW-1:0] data_addr;
	logic [`WISC_XLEN-1:0] data_wdata, data_rdata;

	wisc_core core_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_rdata(fetch_rdata),
		.data_req(data_req),
		.data_we(data_we),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_done(data_done),
		.data_rdata(data_rdata),
		.halted(halted),
		.illegal(illegal),
		.retire(retire),
		.retire_pc(retire_pc),
		.retire_we(retire_we),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	mem_arbiter arb_i (
		.clk(clk),
		.rst_n(rst_n),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_done(host_done),
		.host_rdata(host_rdata),
		.data_req(data_req),
		.data_we(data_we),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_done(data_done),
		.data_rdata(data_rdata),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_rdata(fetch_rdata)
	);

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int period_ns = 8
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(period_ns / 2) clk = ~clk; // Free running, 50 percent duty

endmodule

// ==== tb_wisc_top.sv ====
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module tb_wisc_top import isa_pkg::*; ();

	// 8 LBI, 7 SLBI, 16 ALU, 3 ST/LD pairs and the final HALT
	localparam int rows = 38;
	localparam int mem_pairs = 3;
	localparam opcode_e imm_ops [8] = '{OP_ADDI, OP_SUBI, OP_ORI, OP_ANDI,
		OP_ROLI, OP_SLLI, OP_RORI, OP_SRAI};

	logic clk, rst_n, start;
	logic host_req, host_we, host_done;
	logic [`WISC_MEM_AW-1:0] host_addr, retire_pc;
	logic [`WISC_XLEN-1:0] host_wdata, host_rdata, retire_data;
	logic halted, illegal, retire, retire_we;
	logic [2:0] retire_rd;
	logic [15:0] prog [rows];
	logic [15:0] exp_data [rows];
	logic exp_we [rows];
	logic [2:0] exp_rd [rows];
	logic [15:0] shadow_rf [8];
	logic [15:0] shadow_mem [256];
	logic [7:0] st_addr [mem_pairs];
	int nrows = 0;
	int host_issued = 0;
	int host_done_count = 0;
	int retire_count = 0;
	integer seed;
	logic [31:0] rnd;

	tb_clk_gen #(.period_ns(8)) clk_gen_i (.clk(clk));

	wisc_top wisc_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_done(host_done),
		.host_rdata(host_rdata),
		.start(start),
		.halted(halted),
		.illegal(illegal),
		.retire(retire),
		.retire_pc(retire_pc),
		.retire_we(retire_we),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Expected result of the eight ALU operations, a is Rs
	function automatic logic [15:0] ref_alu(input logic [2:0] kind, input logic [15:0] a,
			input logic [15:0] b);
		logic [3:0] n;
		n = b[3:0];
		case (kind)
			3'd0: return a + b;
			3'd1: return b - a;
			3'd2: return a | b;
			3'd3: return a & b;
			3'd4: return (a << n) | (a >> (5'd16 - {1'b0, n}));
			3'd5: return a << n;
			3'd6: return (a >> n) | (a << (5'd16 - {1'b0, n}));
			default: return $signed(a) >>> n;
		endcase
	endfunction

	task automatic add_row(input logic [15:0] instr, input logic we, input logic [2:0] rd,
			input logic [15:0] data);
		prog[nrows] = instr;
		exp_we[nrows] = we;
		exp_rd[nrows] = rd;
		exp_data[nrows] = data;
		if (we) shadow_rf[rd] = data;
		nrows++;
	endtask

	task automatic build_program();
		logic [2:0] rs, rt, rd, kind;
		logic [4:0] imm5;
		logic [7:0] imm8, addr;
		logic [15:0] b;
		opcode_e op;
		for (int r = 0; r < 8; r++) begin
			rnd = $random(seed);
			imm8 = (r == 7) ? {3'b101, rnd[4:0]} : rnd[7:0]; // R7 is the LD/ST base
			add_row({OP_LBI, 3'(r), imm8}, 1'b1, 3'(r), {{8{imm8[7]}}, imm8});
		end
		for (int r = 0; r < 7; r++) begin
			rnd = $random(seed);
			add_row({OP_SLBI, 3'(r), rnd[7:0]}, 1'b1, 3'(r),
				(shadow_rf[r] << 8) | {8'd0, rnd[7:0]});
		end
		for (int k = 0; k < 16; k++) begin
			rnd = $random(seed);
			rs = rnd[2:0];
			rt = rnd[5:3];
			rd = rnd[8:6] % 3'd7; // Keeps the base register intact
			imm5 = rnd[13:9];
			kind = 3'(k);
			if (k < 8) begin
				op = (k < 4) ? OP_RALU : OP_RSHIFT;
				add_row({op, rs, rt, rd, kind[1:0]}, 1'b1, rd,
					ref_alu(kind, shadow_rf[rs], shadow_rf[rt]));
			end else begin
				if (kind == 3'd2 || kind == 3'd3)
					b = {11'd0, imm5};
				else
					b = {{11{imm5[4]}}, imm5};
				add_row({imm_ops[k - 8], rs, rd, imm5}, 1'b1, rd,
					ref_alu(kind, shadow_rf[rs], b));
			end
		end
		for (int p = 0; p < mem_pairs; p++) begin
			rnd = $random(seed);
			rt = rnd[2:0];
			rd = rnd[5:3] % 3'd7;
			imm5 = rnd[10:6];
			addr = shadow_rf[7][7:0] + {{3{imm5[4]}}, imm5};
			st_addr[p] = addr;
			shadow_mem[addr] = shadow_rf[rt];
			add_row({OP_ST, 3'd7, rt, imm5}, 1'b0, 3'd0, 16'd0);
			add_row({OP_LD, 3'd7, rd, imm5}, 1'b1, rd, shadow_mem[addr]);
		end
		add_row({OP_HALT, 11'd0}, 1'b0, 3'd0, 16'd0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic host_access(input logic we, input logic [7:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= we;
		host_addr <= addr;
		host_wdata <= wdata;
		host_issued++;
		@(posedge clk);
		host_req <= 1'b0;
		do @(negedge clk); while (!host_done);
		rdata = host_rdata;
	endtask

	task automatic host_write(input logic [7:0] addr, input logic [15:0] data);
		logic [15:0] unused_rdata;
		host_access(1'b1, addr, data, unused_rdata);
	endtask

	task automatic host_read_check(input logic [7:0] addr, input logic [15:0] exp);
		logic [15:0] got;
		host_access(1'b0, addr, 16'd0, got);
		assert (got == exp) else report_mismatch("host_rdata", got, exp);
	endtask

	// Compares every retire of one run with the table, in order
	task automatic check_trace(input logic expect_illegal);
		for (int i = 0; i < rows; i++) begin
			do @(negedge clk); while (!retire);
			assert (retire_pc == 8'(i))
				else report_mismatch("retire_pc", 16'(retire_pc), 16'(i));
			assert (retire_we == exp_we[i])
				else report_mismatch("retire_we", 16'(retire_we), 16'(exp_we[i]));
			if (exp_we[i]) begin
				assert (retire_rd == exp_rd[i])
					else report_mismatch("retire_rd", 16'(retire_rd), 16'(exp_rd[i]));
				assert (retire_data == exp_data[i])
					else report_mismatch("retire_data", retire_data, exp_data[i]);
			end
			assert (halted == (i == rows - 1))
				else report_mismatch("halted", 16'(halted), 16'(i == rows - 1));
			assert (illegal == (expect_illegal && i == rows - 1))
				else report_mismatch("illegal", 16'(illegal), 16'(expect_illegal && i == rows - 1));
		end
	endtask

	// Counts done and retire pulses over the whole run
	always @(negedge clk) begin
		if (host_done) begin
			assert (host_done_count < host_issued)
				else abort_run("host_done pulsed with no host request outstanding");
			host_done_count++;
		end
		if (retire) retire_count++;
	end

	initial begin
		repeat (rows * 12 + 200) @(posedge clk);
		abort_run("Simulation timed out waiting for the DUT");
	end

	initial begin
		seed = 32'hebf4_212b;
		rst_n <= 1'b0;
		start <= 1'b0;
		host_req <= 1'b0;
		host_we <= 1'b0;
		host_addr <= '0;
		host_wdata <= '0;
		build_program();
		apply_reset();
		rnd = $random(seed);
		host_write(8'hf0, rnd[15:0]); // Scratch words outside program and data
		host_write(8'hf1, rnd[31:16]);
		host_read_check(8'hf0, rnd[15:0]);
		host_read_check(8'hf1, rnd[31:16]);
		for (int i = 0; i < rows; i++) host_write(8'(i), prog[i]);
		pulse_start();
		fork
			check_trace(1'b0);
			begin
				repeat (40) @(posedge clk);
				host_read_check(8'd5, prog[5]); // Competes with fetch
			end
		join
		for (int p = 0; p < mem_pairs; p++) host_read_check(st_addr[p], shadow_mem[st_addr[p]]);
		assert (retire_count == rows) else abort_run("A retire followed the HALT instruction");
		assert (halted) else abort_run("halted dropped while the core was stopped");

		// Second run, JAL takes the place of HALT
		apply_reset();
		assert (!halted && !illegal) else abort_run("Status flags still set after reset");
		host_write(8'(rows - 1), {5'b00110, 11'd0});
		pulse_start();
		check_trace(1'b1);
		assert (host_done_count == host_issued)
			else abort_run("Number of host_done pulses differs from host requests");
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
alu_destination_decode.sv
alu.sv
mem_arbiter.sv
wisc_core.sv
wisc_top.sv
tb_clk_gen.sv
tb_wisc_top.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_wisc_top
RTL_TOP    = wisc_top
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
